// ==== icache_macros.svh ====
// instruction cache sizing constants shared by the package and the RTL
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// byte address width seen by the fetch unit
`define ICACHE_ADDR_W 20

// line index width, one index per 8-byte line
`define ICACHE_INDEX_W 9

// number of lines in the direct-mapped array
`define ICACHE_LINES 512

// tag width is address minus index minus the 3 offset bits
`define ICACHE_TAG_W 8

// one refill beat, half a line
`define ICACHE_WORD_W 32

// credits that memory grants the cache at reset
`define ICACHE_MEM_CREDITS 1

`endif

// ==== icache_pkg.sv ====
// instruction cache types for the fetch and memory channels and the controller
`include "icache_macros.svh"

package icache_pkg;

        // refill word and full line
        typedef logic [`ICACHE_WORD_W-1:0] word_t;
        typedef logic [2*`ICACHE_WORD_W-1:0] line_t;

        // byte address with the 3 offset bits dropped
        typedef logic [`ICACHE_ADDR_W-4:0] line_addr_t;

        // low bits of a line address pick the line, high bits are the tag
        typedef logic [`ICACHE_INDEX_W-1:0] index_t;
        typedef logic [`ICACHE_TAG_W-1:0] tag_t;

        // fetch request from the core
        typedef struct packed {
                line_addr_t addr;
        } fetch_req_t;

        // fetch response, line data plus the address it belongs to
        typedef struct packed {
                line_addr_t addr;
                line_t data;
        } fetch_rsp_t;

        // refill request to memory
        typedef struct packed {
                line_addr_t addr;
        } mem_req_t;

        // refill beat from memory, upper half comes first
        typedef struct packed {
                word_t data;
                logic last;
        } mem_beat_t;

        // controller states
        typedef enum logic [2:0] {
                st_idle,
                st_lookup,
                st_compare,
                st_request,
                st_fill_upper,
                st_fill_lower,
                st_respond,
                st_flush
        } ctrl_state_t;

endpackage

// ==== icache_data_ram.sv ====
// instruction cache line array, whole-line registered read and half-line writes
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_data_ram (
        input  logic                clk,
        input  logic                rd_en,
        input  icache_pkg::index_t  rd_index,
        output icache_pkg::line_t   rd_line,
        input  logic                wr_upper,
        input  logic                wr_lower,
        input  icache_pkg::index_t  wr_index,
        input  icache_pkg::word_t   wr_word
);

        import icache_pkg::*;

        // 512 lines of 64 bits, 4 KB in all
        line_t mem [`ICACHE_LINES];

        // read port, output register holds its value while rd_en is low
        always_ff @(posedge clk) begin
                if (rd_en) begin
                        rd_line <= mem[rd_index];
                end
        end

        // write port, one 32-bit half per cycle
        // the upper half holds the lower byte addresses of the line
        // upper wins if both strobes are up
        always_ff @(posedge clk) begin
                if (wr_upper) begin
                        mem[wr_index][2*`ICACHE_WORD_W-1:`ICACHE_WORD_W] <= wr_word;
                end else if (wr_lower) begin
                        mem[wr_index][`ICACHE_WORD_W-1:0] <= wr_word;
                end
        end

endmodule

// ==== icache_tag_ram.sv ====
// instruction cache tag and valid array with refill write and invalidate-all sweep
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_tag_ram (
        input  logic                clk,
        input  logic                rst,
        input  logic                lookup_en,
        input  icache_pkg::index_t  lookup_index,
        output icache_pkg::tag_t    lookup_tag,
        output logic                lookup_valid,
        input  logic                fill_en,
        input  icache_pkg::index_t  fill_index,
        input  icache_pkg::tag_t    fill_tag,
        input  logic                flush_start,
        output logic                flush_busy
);

        import icache_pkg::*;

        // one tag per line, no reset on the contents
        tag_t tag_mem [`ICACHE_LINES];

        // one valid bit per line
        logic [`ICACHE_LINES-1:0] valid_q;

        // sweep position
        index_t flush_cnt;

        always_ff @(posedge clk) begin
                if (fill_en) begin
                        tag_mem[fill_index] <= fill_tag;
                end
        end

        // lookup result shows up one cycle after the request
        always_ff @(posedge clk) begin
                if (lookup_en) begin
                        lookup_tag <= tag_mem[lookup_index];
                        lookup_valid <= valid_q[lookup_index];
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        valid_q <= '0;
                        flush_busy <= 1'b0;
                        flush_cnt <= '0;
                end else if (flush_busy) begin
                        // clear one line per cycle, stop after the last index
                        valid_q[flush_cnt] <= 1'b0;
                        flush_cnt <= flush_cnt + 1'b1;
                        if (flush_cnt == index_t'(`ICACHE_LINES - 1)) begin
                                flush_busy <= 1'b0;
                        end
                end else if (flush_start) begin
                        flush_busy <= 1'b1;
                        flush_cnt <= '0;
                end else if (fill_en) begin
                        // a completed refill makes the line usable
                        valid_q[fill_index] <= 1'b1;
                end
        end

endmodule

// ==== icache_ctrl.sv ====
// instruction cache controller, fetch lookup, two-beat refill, credits and flush
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_ctrl (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    fetch_req_valid,
        input  icache_pkg::fetch_req_t  fetch_req,
        output logic                    fetch_rsp_valid,
        output icache_pkg::fetch_rsp_t  fetch_rsp,
        output logic                    fetch_credit,
        input  logic                    flush,
        output logic                    mem_req_valid,
        output icache_pkg::mem_req_t    mem_req,
        input  logic                    mem_credit,
        input  logic                    mem_beat_valid,
        input  icache_pkg::mem_beat_t   mem_beat,
        output logic                    rd_en,
        output icache_pkg::index_t      rd_index,
        input  icache_pkg::line_t       rd_line,
        output logic                    wr_upper,
        output logic                    wr_lower,
        output icache_pkg::index_t      wr_index,
        output icache_pkg::word_t       wr_word,
        output logic                    lookup_en,
        output icache_pkg::index_t      lookup_index,
        input  icache_pkg::tag_t        lookup_tag,
        input  logic                    lookup_valid,
        output logic                    fill_en,
        output icache_pkg::index_t      fill_index,
        output icache_pkg::tag_t        fill_tag,
        output logic                    flush_start,
        input  logic                    flush_busy
);

        import icache_pkg::*;

        ctrl_state_t state_q;
        ctrl_state_t state_d;
        line_addr_t addr_q;
        logic pend_q;
        logic flush_pend_q;
        logic boot_done_q;
        logic boot_credit_q;
        logic [3:0] mem_credits_q;
        logic take_new;
        logic take_pend;
        logic hit;
        index_t addr_index;
        tag_t addr_tag;

        assign addr_index = addr_q[`ICACHE_INDEX_W-1:0];
        assign addr_tag = addr_q[`ICACHE_INDEX_W +: `ICACHE_TAG_W];
        assign hit = lookup_valid && (lookup_tag == addr_tag);

        always_comb begin
                state_d = state_q;
                take_new = 1'b0;
                take_pend = 1'b0;
                flush_start = 1'b0;
                lookup_en = 1'b0;
                case (state_q)
                        // respond also takes a new fetch, the credit went out this cycle
                        st_idle, st_respond: begin
                                state_d = st_idle;
                                if (fetch_req_valid) begin
                                        take_new = 1'b1;
                                        lookup_en = 1'b1;
                                        state_d = st_compare;
                                end else if (pend_q) begin
                                        // fetch held over from the sweep
                                        take_pend = 1'b1;
                                        lookup_en = 1'b1;
                                        state_d = st_compare;
                                end else if ((flush || flush_pend_q) && state_q == st_idle) begin
                                        flush_start = 1'b1;
                                        state_d = st_flush;
                                end
                        end
                        // replay read after a refill, the line is known to be present
                        st_lookup: begin
                                lookup_en = 1'b1;
                                state_d = st_respond;
                        end
                        st_compare: state_d = hit ? st_respond : st_request;
                        st_request: begin
                                if (mem_req_valid) begin
                                        state_d = st_fill_upper;
                                end
                        end
                        st_fill_upper: begin
                                if (mem_beat_valid) begin
                                        state_d = st_fill_lower;
                                end
                        end
                        st_fill_lower: begin
                                if (mem_beat_valid && mem_beat.last) begin
                                        state_d = st_lookup;
                                end
                        end
                        st_flush: begin
                                if (!flush_busy) begin
                                        state_d = st_idle;
                                end
                        end
                        default: state_d = st_idle;
                endcase
        end

        // lookup goes to both arrays with the same index
        assign rd_en = lookup_en;
        assign lookup_index = take_new ? fetch_req.addr[`ICACHE_INDEX_W-1:0] : addr_index;
        assign rd_index = lookup_index;

        // response straight from the registered line and address
        assign fetch_rsp_valid = (state_q == st_respond);
        assign fetch_rsp.addr = addr_q;
        assign fetch_rsp.data = rd_line;
        assign fetch_credit = boot_credit_q || (state_q == st_respond);

        // request only while a memory credit is held
        assign mem_req_valid = (state_q == st_request) && (mem_credits_q != 4'd0);
        assign mem_req.addr = addr_q;

        // first beat is the upper half, last beat the lower half and the tag
        assign wr_upper = (state_q == st_fill_upper) && mem_beat_valid;
        assign wr_lower = (state_q == st_fill_lower) && mem_beat_valid;
        assign wr_index = addr_index;
        assign wr_word = mem_beat.data;
        assign fill_en = wr_lower && mem_beat.last;
        assign fill_index = addr_index;
        assign fill_tag = addr_tag;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state_q <= st_idle;
                        pend_q <= 1'b0;
                        flush_pend_q <= 1'b0;
                        boot_done_q <= 1'b0;
                        boot_credit_q <= 1'b0;
                        mem_credits_q <= 4'(`ICACHE_MEM_CREDITS);
                end else begin
                        state_q <= state_d;
                        // single credit pulse in the first cycle out of reset
                        boot_done_q <= 1'b1;
                        boot_credit_q <= ~boot_done_q;
                        if (fetch_req_valid && !take_new) begin
                                pend_q <= 1'b1;
                        end else if (take_pend) begin
                                pend_q <= 1'b0;
                        end
                        if (flush_start) begin
                                flush_pend_q <= 1'b0;
                        end else if (flush) begin
                                flush_pend_q <= 1'b1;
                        end
                        case ({mem_credit, mem_req_valid})
                                2'b10: mem_credits_q <= mem_credits_q + 4'd1;
                                2'b01: mem_credits_q <= mem_credits_q - 4'd1;
                                default: mem_credits_q <= mem_credits_q;
                        endcase
                end
        end

        // fetch address, only one fetch is ever in flight
        always_ff @(posedge clk) begin
                if (fetch_req_valid) begin
                        addr_q <= fetch_req.addr;
                end
        end

endmodule

// ==== icache_top.sv ====
// instruction cache top level, controller with tag and line arrays
`timescale 1ns/100ps

module icache_top (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    fetch_req_valid,
        input  icache_pkg::fetch_req_t  fetch_req,
        output logic                    fetch_rsp_valid,
        output icache_pkg::fetch_rsp_t  fetch_rsp,
        output logic                    fetch_credit,
        input  logic                    flush,
        output logic                    mem_req_valid,
        output icache_pkg::mem_req_t    mem_req,
        input  logic                    mem_credit,
        input  logic                    mem_beat_valid,
        input  icache_pkg::mem_beat_t   mem_beat
);

        import icache_pkg::*;

        // line array side
        logic rd_en;
        index_t rd_index;
        line_t rd_line;
        logic wr_upper;
        logic wr_lower;
        index_t wr_index;
        word_t wr_word;

        // tag array side
        logic lookup_en;
        index_t lookup_index;
        tag_t lookup_tag;
        logic lookup_valid;
        logic fill_en;
        index_t fill_index;
        tag_t fill_tag;
        logic flush_start;
        logic flush_busy;

        icache_ctrl u_ctrl (
                .clk             (clk),
                .rst             (rst),
                .fetch_req_valid (fetch_req_valid),
                .fetch_req       (fetch_req),
                .fetch_rsp_valid (fetch_rsp_valid),
                .fetch_rsp       (fetch_rsp),
                .fetch_credit    (fetch_credit),
                .flush           (flush),
                .mem_req_valid   (mem_req_valid),
                .mem_req         (mem_req),
                .mem_credit      (mem_credit),
                .mem_beat_valid  (mem_beat_valid),
                .mem_beat        (mem_beat),
                .rd_en           (rd_en),
                .rd_index        (rd_index),
                .rd_line         (rd_line),
                .wr_upper        (wr_upper),
                .wr_lower        (wr_lower),
                .wr_index        (wr_index),
                .wr_word         (wr_word),
                .lookup_en       (lookup_en),
                .lookup_index    (lookup_index),
                .lookup_tag      (lookup_tag),
                .lookup_valid    (lookup_valid),
                .fill_en         (fill_en),
                .fill_index      (fill_index),
                .fill_tag        (fill_tag),
                .flush_start     (flush_start),
                .flush_busy      (flush_busy)
        );

        icache_tag_ram u_tag_ram (
                .clk          (clk),
                .rst          (rst),
                .lookup_en    (lookup_en),
                .lookup_index (lookup_index),
                .lookup_tag   (lookup_tag),
                .lookup_valid (lookup_valid),
                .fill_en      (fill_en),
                .fill_index   (fill_index),
                .fill_tag     (fill_tag),
                .flush_start  (flush_start),
                .flush_busy   (flush_busy)
        );

        icache_data_ram u_data_ram (
                .clk      (clk),
                .rd_en    (rd_en),
                .rd_index (rd_index),
                .rd_line  (rd_line),
                .wr_upper (wr_upper),
                .wr_lower (wr_lower),
                .wr_index (wr_index),
                .wr_word  (wr_word)
        );

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset source, 100 ns period with a 10-cycle synchronous reset
`timescale 1ns/100ps

module tb_clock_gen (
        output logic clk,
        output logic rst
);

        // free-running clock, 50 ns per phase
        initial begin
                clk = 1'b0;
                forever begin
                        #50 clk = ~clk;
                end
        end

        // reset high over the first 10 rising edges, dropped on a falling edge
        initial begin
                rst = 1'b1;
                repeat (10) @(negedge clk);
                rst = 1'b0;
        end

endmodule

// ==== icache_tb.sv ====
// instruction cache testbench with a memory model, a tag scoreboard and a reference line function
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_tb;

        import icache_pkg::*;

        localparam int timeout_cycles = 2000;
        localparam line_addr_t addr_a = {8'h00, 9'h123};
        // same index as addr_a but another tag
        localparam line_addr_t addr_b = {8'h5a, 9'h123};
        localparam line_addr_t addr_c = {8'h3c, 9'h0a5};

        logic clk;
        logic rst;

        // DUT inputs start low at time zero
        logic fetch_req_valid = 1'b0;
        fetch_req_t fetch_req = '0;
        logic flush = 1'b0;
        logic mem_credit = 1'b0;
        logic mem_beat_valid = 1'b0;
        mem_beat_t mem_beat = '0;

        logic fetch_rsp_valid;
        fetch_rsp_t fetch_rsp;
        logic fetch_credit;
        logic mem_req_valid;
        mem_req_t mem_req;

        // core side credit and traffic counters
        int credits = 0;
        int credit_pulses = 0;
        int mem_req_count = 0;
        int rsp_count = 0;
        int exp_misses = 0;
        int cyc = 0;
        int req_cyc = 0;
        int last_latency = 0;
        line_addr_t last_req_addr;
        line_addr_t exp_addr;
        line_addr_t exp_addr_q[$];

        // memory model phases are 0 idle, 1 delay, 2 gap and 3 credit return
        line_addr_t req_q[$];
        line_addr_t mm_addr;
        int mm_phase = 0;
        int mm_wait = 0;

        // scoreboard of the direct-mapped tag array
        bit sb_valid [`ICACHE_LINES];
        tag_t sb_tag [`ICACHE_LINES];

        int checks = 0;
        int errors = 0;
        int test_num = 0;
        int test_errs = 0;
        string test_name;
        int req_base;
        int miss_base;
        int rsp_base;
        int seed;
        line_addr_t rnd_addr;

        tb_clock_gen clock_gen (.clk(clk), .rst(rst));

        icache_top uut (
                .clk             (clk),
                .rst             (rst),
                .fetch_req_valid (fetch_req_valid),
                .fetch_req       (fetch_req),
                .fetch_rsp_valid (fetch_rsp_valid),
                .fetch_rsp       (fetch_rsp),
                .fetch_credit    (fetch_credit),
                .flush           (flush),
                .mem_req_valid   (mem_req_valid),
                .mem_req         (mem_req),
                .mem_credit      (mem_credit),
                .mem_beat_valid  (mem_beat_valid),
                .mem_beat        (mem_beat)
        );

        // memory contents are a hash of the byte address
        function automatic word_t mem_word(input logic [`ICACHE_ADDR_W-1:0] byte_addr);
                word_t w;
                w = {12'h000, byte_addr} * 32'h9e3779b1;
                w = w ^ (w >> 15) ^ 32'h6a09e667;
                return w;
        endfunction

        // upper half holds the lower byte address
        function automatic line_t expected_line(input line_addr_t a);
                logic [`ICACHE_ADDR_W-1:0] base;
                base = {a, 3'b000};
                return {mem_word(base), mem_word(base + 20'd4)};
        endfunction

        // direct-mapped rule that returns 1 on a miss and installs the line
        function automatic bit predict_miss(input line_addr_t a);
                index_t idx;
                tag_t tg;
                bit miss;
                idx = a[`ICACHE_INDEX_W-1:0];
                tg = a[`ICACHE_INDEX_W +: `ICACHE_TAG_W];
                miss = !sb_valid[idx] || (sb_tag[idx] != tg);
                sb_valid[idx] = 1'b1;
                sb_tag[idx] = tg;
                return miss;
        endfunction

        task automatic check_line(input string name, input line_t got, input line_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("** Error: %s expected %h got %h", name, exp, got);
                end
        endtask

        task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("** Error: %s expected %h got %h", name, exp, got);
                end
        endtask

        task automatic check_count(input string name, input int got, input int exp);
                checks++;
                if (got != exp) begin
                        errors++;
                        $display("** Error: %s expected %h got %h", name, exp, got);
                end
        endtask

        task automatic finish_run();
                $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        endtask

        task automatic timed_out(input string what);
                errors++;
                $display("no %s within %0d cycles, run stopped", what, timeout_cycles);
                finish_run();
        endtask

        task automatic start_test(input string name);
                test_num++;
                test_name = name;
                test_errs = errors;
        endtask

        task automatic end_test();
                if (errors == test_errs) begin
                        $display("test %0d %s: ok", test_num, test_name);
                end else begin
                        $display("test %0d %s: %0d errors", test_num, test_name, errors - test_errs);
                end
        endtask

        task automatic wait_credit();
                int waited;
                waited = 0;
                while (credits == 0) begin
                        @(negedge clk);
                        waited++;
                        if (waited > timeout_cycles) begin
                                timed_out("fetch credit");
                        end
                end
        endtask

        // one fetch from the core spends a credit and waits for its response
        task automatic do_fetch(input line_addr_t a);
                int waited;
                int rsp_before;
                wait_credit();
                if (predict_miss(a)) begin
                        exp_misses++;
                end
                exp_addr_q.push_back(a);
                rsp_before = rsp_count;
                credits--;
                fetch_req_valid = 1'b1;
                fetch_req.addr = a;
                @(negedge clk);
                fetch_req_valid = 1'b0;
                waited = 0;
                while (rsp_count == rsp_before) begin
                        @(negedge clk);
                        waited++;
                        if (waited > timeout_cycles) begin
                                timed_out("fetch response");
                        end
                end
        endtask

        // outputs are all registered so the rising edge sees last cycle's values
        always @(posedge clk) begin
                if (!rst) begin
                        if (fetch_credit) begin
                                credits++;
                                credit_pulses++;
                                if (credits > 1) begin
                                        errors++;
                                        $display("core was handed more than one fetch credit");
                                end
                        end
                        if (fetch_req_valid) begin
                                req_cyc = cyc;
                        end
                        if (mem_req_valid) begin
                                mem_req_count++;
                                last_req_addr = mem_req.addr;
                                req_q.push_back(mem_req.addr);
                        end
                        if (fetch_rsp_valid) begin
                                rsp_count++;
                                last_latency = cyc - req_cyc;
                                if (exp_addr_q.size() == 0) begin
                                        errors++;
                                        $display("response arrived with no fetch outstanding");
                                end else begin
                                        exp_addr = exp_addr_q.pop_front();
                                        check_addr("fetch_rsp.addr", fetch_rsp.addr, exp_addr);
                                        check_line("fetch_rsp.data", fetch_rsp.data,
                                                   expected_line(exp_addr));
                                end
                        end
                end
                cyc++;
        end

        // memory model answers after a random delay with two beats and a random gap, then credit
        always @(negedge clk) begin
                mem_beat_valid = 1'b0;
                mem_credit = 1'b0;
                if (rst) begin
                        mm_phase = 0;
                end else begin
                        case (mm_phase)
                                0: begin
                                        if (req_q.size() > 0) begin
                                                mm_addr = req_q.pop_front();
                                                mm_wait = $urandom % 6;
                                                mm_phase = 1;
                                        end
                                end
                                1, 2: begin
                                        if (mm_wait > 0) begin
                                                mm_wait--;
                                        end else begin
                                                mem_beat_valid = 1'b1;
                                                mem_beat.last = (mm_phase == 2);
                                                mem_beat.data = mem_word({mm_addr,
                                                                          (mm_phase == 2), 2'b00});
                                                mm_wait = $urandom % 3;
                                                mm_phase = mm_phase + 1;
                                        end
                                end
                                default: begin
                                        mem_credit = 1'b1;
                                        mm_phase = 0;
                                end
                        endcase
                end
        end

        initial begin
                seed = $urandom(32'h5d0cf527);
                repeat (11) @(negedge clk);

                // reset hands out one credit and nothing else
                start_test("reset credit");
                wait_credit();
                repeat (20) @(negedge clk);
                check_count("fetch_credit pulses", credit_pulses, 1);
                check_count("mem_req_valid pulses", mem_req_count, 0);
                check_count("fetch_rsp_valid pulses", rsp_count, 0);
                end_test();

                start_test("cold miss");
                req_base = mem_req_count;
                do_fetch(addr_a);
                check_count("mem_req_valid pulses", mem_req_count - req_base, 1);
                check_addr("mem_req.addr", last_req_addr, addr_a);
                end_test();

                start_test("hit");
                req_base = mem_req_count;
                do_fetch(addr_a);
                check_count("mem_req_valid pulses", mem_req_count - req_base, 0);
                check_count("hit latency", last_latency, 2);
                end_test();

                // addr_a is resident so starting with addr_b makes every fetch evict
                start_test("conflict eviction");
                req_base = mem_req_count;
                do_fetch(addr_b);
                do_fetch(addr_a);
                do_fetch(addr_b);
                do_fetch(addr_a);
                check_count("mem_req_valid pulses", mem_req_count - req_base, 4);
                end_test();

                start_test("flush");
                do_fetch(addr_c);
                do_fetch(addr_c);
                req_base = mem_req_count;
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                foreach (sb_valid[i]) begin
                        sb_valid[i] = 1'b0;
                end
                repeat (`ICACHE_LINES + 4) @(negedge clk);
                do_fetch(addr_c);
                check_count("mem_req_valid pulses", mem_req_count - req_base, 1);
                end_test();

                // 8 indexes by 4 tags keeps hits and evictions both frequent
                start_test("random run");
                req_base = mem_req_count;
                miss_base = exp_misses;
                rsp_base = rsp_count;
                for (int i = 0; i < 200; i++) begin
                        rnd_addr = {tag_t'($urandom % 4), index_t'($urandom % 8)};
                        do_fetch(rnd_addr);
                end
                check_count("mem_req_valid pulses", mem_req_count - req_base,
                            exp_misses - miss_base);
                check_count("fetch_rsp_valid pulses", rsp_count - rsp_base, 200);
                end_test();

                finish_run();
        end

endmodule

// ==== verilog.f ====
+incdir+.
icache_pkg.sv
icache_data_ram.sv
icache_tag_ram.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_data_ram.sv
      - icache_tag_ram.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - icache_tb.sv
